/* flist.f */
exe_pkg.sv
exe_forward.sv
exe_alu.sv
exe_branch.sv
exe_result_sel.sv
exe_pipe_reg.sv
exe_stage.sv
tb_exe_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exe_stage -f flist.f -o sim_exe_stage
status=$?
if [ $status -ne 0 ]
then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_exe_stage
status=$?
if [ $status -ne 0 ]
then
   echo "Simulation failed with status $status"
   exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* tb_exe_stage.sv */
// Self-checking testbench for exe_stage; one item in flight at the input, I-cache range from exe_pkg
`timescale 1ns/1ps

module tb_exe_stage
   import exe_pkg::*;
();

   localparam int   N_VEC   = 20;            // Table entries
   localparam int   TIMEOUT = 200;           // Cycles per wait
   localparam fwd_t NO_FWD  = '0;

   logic             clk_in;
   logic             i_rst_n;
   logic             i_pipe_flush;
   logic             i_dec_valid;
   dec_to_exe_t      i_dec_data;
   logic             o_dec_ready;
   fwd_t             i_fwd_mem;
   fwd_t             i_fwd_wb;
   logic             o_mem_valid;
   exe_to_mem_t      o_mem_data;
   logic             i_mem_ready;
   logic             o_rld_pc;
   logic [PC_SZ-1:0] o_rld_pc_addr;

   // -------------------- Stimulus table
   dec_to_exe_t      vec_dec      [N_VEC];
   fwd_t             vec_mem      [N_VEC];
   fwd_t             vec_wb       [N_VEC];
   exe_to_mem_t      vec_exp      [N_VEC];
   logic             vec_rld      [N_VEC];
   logic [PC_SZ-1:0] vec_rld_addr [N_VEC];
   int               n_vec;
   exe_to_mem_t      exp_q [$];              // Records owed by the memory side
   logic             hold_ready;             // Force memory back-pressure

   exe_stage dut (.*);

   initial
   begin
      clk_in = 1'b0;
      forever
         #10 clk_in = ~clk_in;               // 20 ns period
   end

   // -------------------- Reporting
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_mem(input exe_to_mem_t got, input exe_to_mem_t exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: memory record %h, expected %h",
                             $time, got, exp));
   endtask

   task automatic check_rld(input logic got, input logic [PC_SZ-1:0] got_addr,
                            input logic exp, input logic [PC_SZ-1:0] exp_addr, input int k);
      if (got !== exp || (exp && got_addr !== exp_addr))
         abort_run($sformatf("CHECK FAILED at %0t: entry %0d reload %b/%h, expected %b/%h",
                             $time, k, got, got_addr, exp, exp_addr));
   endtask

   // -------------------- Record builders
   function automatic dec_to_exe_t new_dec(input logic [PC_SZ-1:0] pc);
      dec_to_exe_t d;
      d                = '0;
      d.pc             = pc;
      d.predicted_addr = pc + 32'd4;         // Fetch guessed fall through
      d.i_type         = ALU;
      return d;
   endfunction

   // Fields every valid item carries into the record
   function automatic exe_to_mem_t new_exp(input dec_to_exe_t d);
      exe_to_mem_t e;
      e                = '0;
      e.pc             = d.pc;
      e.i_type         = d.i_type;
      e.predicted_addr = d.predicted_addr;
      e.rd_addr        = d.rd_addr;
      return e;
   endfunction

   function automatic fwd_t fwd_res(input logic v, input logic wr,
                                    input logic [GPR_ASZ-1:0] a, input logic [XLEN-1:0] data);
      fwd_t f;
      f.valid   = v;
      f.rd_wr   = wr;
      f.rd_addr = a;
      f.rd_data = data;
      return f;
   endfunction

   function automatic dec_to_exe_t alu_dec(
      input alu_op_e op,
      input logic [GPR_ASZ-1:0] rs1a, input logic [XLEN-1:0] rs1d,
      input logic [GPR_ASZ-1:0] rs2a, input logic [XLEN-1:0] rs2d,
      input logic [GPR_ASZ-1:0] rd
   );
      dec_to_exe_t d;
      d          = new_dec(32'h100);
      d.alu_op   = op;
      d.rs1_addr = rs1a;
      d.rs1_data = rs1d;
      d.rs1_rd   = 1'b1;
      d.rs2_addr = rs2a;
      d.rs2_data = rs2d;
      d.rs2_rd   = 1'b1;
      d.rd_addr  = rd;
      d.rd_wr    = 1'b1;
      return d;
   endfunction

   function automatic exe_to_mem_t alu_exp(input dec_to_exe_t d, input logic [XLEN-1:0] v);
      exe_to_mem_t e;
      e         = new_exp(d);
      e.rd_wr   = d.rd_wr && (d.rd_addr != '0);   // x0 never written
      e.rd_data = v;
      return e;
   endfunction

   // Branch reads x1 and x2
   function automatic dec_to_exe_t br_dec(
      input br_op_e op, input logic [PC_SZ-1:0] pc, input logic [XLEN-1:0] imm,
      input logic [XLEN-1:0] rs1d, input logic [XLEN-1:0] rs2d,
      input logic [PC_SZ-1:0] pred, input logic [GPR_ASZ-1:0] rd
   );
      dec_to_exe_t d;
      d                = alu_dec(ADD, 5'd1, rs1d, 5'd2, rs2d, rd);
      d.pc             = pc;
      d.i_type         = BR;
      d.br_op          = op;
      d.imm            = imm;
      d.predicted_addr = pred;
      d.rd_wr          = (rd != '0);
      return d;
   endfunction

   function automatic exe_to_mem_t br_exp(input dec_to_exe_t d, input logic [PC_SZ-1:0] br_pc,
                                          input logic mis, input logic link);
      exe_to_mem_t e;
      e        = new_exp(d);
      e.br_pc  = br_pc;
      e.mispre = mis;
      if (link && !mis && d.rd_wr && d.rd_addr != '0)
      begin
         e.rd_wr   = 1'b1;
         e.rd_data = d.pc + 32'd4;           // Link value
      end
      return e;
   endfunction

   // Base in x2, store data in x6
   function automatic dec_to_exe_t ls_dec(
      input instr_type_e t, input ls_size_e size, input logic uns,
      input logic [XLEN-1:0] base, input logic [XLEN-1:0] imm,
      input logic [XLEN-1:0] std, input logic [GPR_ASZ-1:0] rd
   );
      dec_to_exe_t d;
      d             = alu_dec(ADD, 5'd2, base, 5'd6, std, rd);
      d.pc          = 32'h700;
      d.i_type      = t;
      d.ls_size     = size;
      d.ls_unsigned = uns;
      d.imm         = imm;
      d.rs2_rd      = (t == ST);
      d.rd_wr       = (rd != '0);
      return d;
   endfunction

   function automatic exe_to_mem_t ls_exp(input dec_to_exe_t d, input logic [XLEN-1:0] addr,
                                          input logic mis, input logic inv);
      exe_to_mem_t e;
      e          = new_exp(d);
      e.is_ld    = (d.i_type == LD);
      e.is_st    = (d.i_type == ST);
      e.rd_wr    = e.is_ld && d.rd_wr && (d.rd_addr != '0);
      e.ls_addr  = addr;
      e.ls_size  = d.ls_size;
      e.zero_ext = d.ls_unsigned;
      e.st_data  = e.is_st ? d.rs2_data : '0;
      e.mis      = mis;
      e.inv_flag = inv;
      return e;
   endfunction

   task automatic add_vec(input dec_to_exe_t d, input fwd_t fm, input fwd_t fw,
                          input exe_to_mem_t e, input logic rld, input logic [PC_SZ-1:0] ra);
      vec_dec[n_vec]      = d;
      vec_mem[n_vec]      = fm;
      vec_wb[n_vec]       = fw;
      vec_exp[n_vec]      = e;
      vec_rld[n_vec]      = rld;
      vec_rld_addr[n_vec] = ra;
      n_vec++;
   endtask

   task automatic build_table();
      dec_to_exe_t d;
      exe_to_mem_t e;
      d = alu_dec(ADD, 5'd1, 32'd5, 5'd2, 32'd7, 5'd3);
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'd12), 1'b0, '0);
      d = alu_dec(SUB, 5'd1, 32'd3, 5'd2, 32'd5, 5'd4);
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'hFFFF_FFFE), 1'b0, '0);
      d = alu_dec(SRA, 5'd1, 32'h8000_0010, 5'd2, 32'd0, 5'd5);
      d.sel_y_imm = 1'b1;                    // Shift by imm
      d.imm       = 32'd4;
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'hF800_0001), 1'b0, '0);
      d = alu_dec(SLT, 5'd1, 32'hFFFF_FFFF, 5'd2, 32'd1, 5'd6);
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'd1), 1'b0, '0);   // -1 < 1 signed
      d = alu_dec(SLTU, 5'd1, 32'hFFFF_FFFF, 5'd2, 32'd1, 5'd7);
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'd0), 1'b0, '0);
      d = alu_dec(LUI, 5'd1, 32'd0, 5'd2, 32'd0, 5'd0);
      d.sel_y_imm = 1'b1;
      d.imm       = 32'h1234_5000;
      add_vec(d, NO_FWD, NO_FWD, alu_exp(d, 32'h1234_5000), 1'b0, '0);  // rd x0
      // Forwarding
      d = alu_dec(ADD, 5'd7, 32'd1, 5'd8, 32'd2, 5'd9);
      add_vec(d, fwd_res(1'b1, 1'b1, 5'd7, 32'd100), fwd_res(1'b1, 1'b1, 5'd7, 32'd200),
              alu_exp(d, 32'd102), 1'b0, '0);                  // MEM beats WB
      d = alu_dec(ADD, 5'd0, 32'd0, 5'd8, 32'd2, 5'd10);
      add_vec(d, fwd_res(1'b1, 1'b0, 5'd8, 32'd50), fwd_res(1'b1, 1'b1, 5'd8, 32'd30),
              alu_exp(d, 32'd30), 1'b0, '0);                   // MEM rd_wr low
      d = alu_dec(ADD, 5'd0, 32'd4, 5'd2, 32'd6, 5'd11);
      add_vec(d, fwd_res(1'b1, 1'b1, 5'd0, 32'd77), fwd_res(1'b0, 1'b1, 5'd2, 32'd55),
              alu_exp(d, 32'd10), 1'b0, '0);                   // x0 and invalid WB
      // -------------------- Branches and jumps
      d = br_dec(BEQ, 32'h200, 32'h40, 32'd9, 32'd9, 32'h204, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, br_exp(d, 32'h240, 1'b1, 1'b0), 1'b1, 32'h240);
      d = br_dec(BLT, 32'h300, 32'h80, 32'd5, 32'hFFFF_FFFD, 32'h304, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, br_exp(d, 32'h304, 1'b0, 1'b0), 1'b0, '0);
      d = br_dec(BGEU, 32'h340, 32'hFFFF_FFF0, 32'hFFFF_FFFD, 32'd5, 32'h330, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, br_exp(d, 32'h330, 1'b0, 1'b0), 1'b0, '0);  // Backward
      d = br_dec(JAL, 32'h400, 32'h100, 32'd0, 32'd0, 32'h500, 5'd1);
      add_vec(d, NO_FWD, NO_FWD, br_exp(d, 32'h500, 1'b0, 1'b1), 1'b0, '0);
      d = br_dec(JALR, 32'h600, 32'h20, 32'h1001, 32'd0, 32'h604, 5'd1);
      add_vec(d, NO_FWD, NO_FWD, br_exp(d, 32'h1020, 1'b1, 1'b1), 1'b1, 32'h1020);
      // Loads and stores
      d = ls_dec(LD, HALF, 1'b1, 32'h2000, 32'd6, 32'd0, 5'd4);
      add_vec(d, NO_FWD, NO_FWD, ls_exp(d, 32'h2006, 1'b0, 1'b0), 1'b0, '0);
      d = ls_dec(LD, WORD, 1'b0, 32'h1000, 32'd2, 32'd0, 5'd4);
      add_vec(d, NO_FWD, NO_FWD, ls_exp(d, 32'h1002, 1'b1, 1'b0), 1'b0, '0);  // Load in IC
      d = ls_dec(ST, WORD, 1'b0, 32'h1000, 32'hFFC, 32'hDEAD_BEEF, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, ls_exp(d, 32'h1FFC, 1'b0, 1'b1), 1'b0, '0);
      d = ls_dec(ST, BYTE, 1'b0, 32'h2000, 32'd0, 32'hA5, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, ls_exp(d, 32'h2000, 1'b0, 1'b0), 1'b0, '0);  // Above IC
      d = ls_dec(ST, HALF, 1'b0, 32'h1000, 32'd1, 32'h1234, 5'd0);
      add_vec(d, NO_FWD, NO_FWD, ls_exp(d, 32'h1001, 1'b1, 1'b1), 1'b0, '0);
      d = new_dec(32'h800);
      d.i_type  = ILL;                       // Bubble with no writes
      d.rd_addr = 5'd3;
      d.rd_wr   = 1'b1;
      e         = new_exp(d);
      e.rd_addr = '0;                        // No destination on a bubble
      add_vec(d, NO_FWD, NO_FWD, e, 1'b0, '0);
   endtask

   // -------------------- Handshake helpers
   task automatic wait_ready();
      int n;
      n = 0;
      while (!o_dec_ready)
      begin
         @(negedge clk_in);
         #1;
         n++;
         if (n > TIMEOUT)
            abort_run("Timeout: o_dec_ready stayed low and the stage never accepted the item");
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_vec(input int k);
      i_dec_valid = 1'b1;
      i_dec_data  = vec_dec[k];
      i_fwd_mem   = vec_mem[k];
      i_fwd_wb    = vec_wb[k];
      #1;
      check_rld(o_rld_pc, o_rld_pc_addr, vec_rld[k], vec_rld_addr[k], k);
      wait_ready();
      @(posedge clk_in);                     // Item accepted here
      exp_q.push_back(vec_exp[k]);
      @(negedge clk_in);
      if (!o_mem_valid)
         abort_run("o_mem_valid did not rise one cycle after the item was accepted");
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 || o_mem_valid)
      begin
         @(negedge clk_in);
         #2;                                 // After the monitor's sample
         n++;
         if (n > TIMEOUT)
            abort_run("Timeout: records still pending at the memory output");
      end
   endtask

   // -------------------- Memory side monitor
   initial
   begin
      void'($urandom(32'h7f3d));
      i_mem_ready = 1'b0;
      forever
      begin
         @(negedge clk_in);
         i_mem_ready = hold_ready ? 1'b0 : (($urandom % 4) != 0);   // Ready 3 of 4
         #1;
         if (o_mem_valid && exp_q.size() == 0)
            abort_run("A record appeared at the memory output that was never sent");
         else if (o_mem_valid)
         begin
            check_mem(o_mem_data, exp_q[0]);  // Also proves held data is stable
            if (i_mem_ready)
               void'(exp_q.pop_front());
         end
      end
   end

   // -------------------- Main sequence
   initial
   begin
      i_rst_n      = 1'b0;
      i_pipe_flush = 1'b0;
      i_dec_valid  = 1'b0;
      i_dec_data   = '0;
      i_fwd_mem    = '0;
      i_fwd_wb     = '0;
      hold_ready   = 1'b0;
      n_vec        = 0;
      build_table();
      repeat (4) @(posedge clk_in);          // 4 reset cycles
      @(negedge clk_in);
      if (o_dec_ready || o_mem_valid || o_rld_pc)
         abort_run("Outputs were not quiet while reset was held");
      i_rst_n = 1'b1;
      for (int k = 0; k < N_VEC; k++)
         send_vec(k);
      i_dec_valid = 1'b0;
      wait_drain();
      // Flush drops a held record
      hold_ready = 1'b1;
      @(negedge clk_in);
      send_vec(0);
      i_dec_valid  = 1'b0;
      i_pipe_flush = 1'b1;
      @(negedge clk_in);
      i_pipe_flush = 1'b0;
      void'(exp_q.pop_back());               // Record is gone
      #1;
      if (o_mem_valid)
         abort_run("o_mem_valid still high after a pipeline flush");
      hold_ready = 1'b0;
      @(negedge clk_in);
      send_vec(3);                           // Next item flows normally
      i_dec_valid = 1'b0;
      wait_drain();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* exe_stage.sv */
// Execute stage top; every unit is one cycle, ready stays low until the first edge after reset
`timescale 1ns/1ps

module exe_stage
   import exe_pkg::*;
(
   input  logic             clk_in,
   input  logic             i_rst_n,
   input  logic             i_pipe_flush,
   // Decode side
   input  logic             i_dec_valid,
   input  dec_to_exe_t      i_dec_data,
   output logic             o_dec_ready,
   // Forwarded results
   input  fwd_t             i_fwd_mem,
   input  fwd_t             i_fwd_wb,
   // Memory side
   output logic             o_mem_valid,
   output exe_to_mem_t      o_mem_data,
   input  logic             i_mem_ready,
   // Fetch reload
   output logic             o_rld_pc,
   output logic [PC_SZ-1:0] o_rld_pc_addr
);

   logic            run_q;                   // Out of reset
   logic            full;
   logic            xfer_in;
   logic            xfer_out;
   logic [XLEN-1:0] rs1_val;
   logic [XLEN-1:0] rs2_val;
   logic [XLEN-1:0] alu_result;
   br_res_t         br_res;
   exe_to_mem_t     exe_dout;

   // -------------------- Handshake
   always_ff @(posedge clk_in or negedge i_rst_n)
   begin
      if (!i_rst_n)
         run_q <= 1'b0;
      else
         run_q <= 1'b1;
   end

   assign xfer_out    = full & i_mem_ready;                   // Record leaves
   assign o_dec_ready = run_q & (!full | xfer_out);           // Room now or next edge
   assign xfer_in     = i_dec_valid & o_dec_ready;            // Record enters
   assign o_mem_valid = full;

   // -------------------- Units
   exe_forward u_forward (
      .i_dec(i_dec_data), .i_fwd_mem(i_fwd_mem), .i_fwd_wb(i_fwd_wb),
      .o_rs1_val(rs1_val), .o_rs2_val(rs2_val)
   );

   exe_alu u_alu (
      .i_dec(i_dec_data), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .o_result(alu_result)
   );

   exe_branch u_branch (
      .i_dec(i_dec_data), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .o_br_res(br_res)
   );

   exe_result_sel u_result_sel (
      .i_dec_valid(i_dec_valid), .i_dec(i_dec_data),
      .i_rs2_val(rs2_val), .i_rs1_val(rs1_val),
      .i_alu_result(alu_result), .i_br_res(br_res),
      .o_exe_dout(exe_dout), .o_rld_pc(o_rld_pc), .o_rld_pc_addr(o_rld_pc_addr)
   );

   exe_pipe_reg u_pipe_reg (
      .clk_in(clk_in), .i_rst_n(i_rst_n), .i_flush(i_pipe_flush),
      .i_write(xfer_in), .i_data(exe_dout),
      .i_read(xfer_out), .o_full(full), .o_data(o_mem_data)
   );

endmodule

/* exe_pipe_reg.sv */
// Single-entry EXE/MEM register; flush wins over a write in the same cycle
`timescale 1ns/1ps

module exe_pipe_reg
   import exe_pkg::*;
(
   input  logic        clk_in,
   input  logic        i_rst_n,
   input  logic        i_flush,              // Drop the held record
   input  logic        i_write,              // Load from execute
   input  exe_to_mem_t i_data,
   input  logic        i_read,               // Taken by memory stage
   output logic        o_full,
   output exe_to_mem_t o_data
);

   logic        full_q;
   exe_to_mem_t data_q;

   // -------------------- Full flag
   always_ff @(posedge clk_in or negedge i_rst_n)
   begin
      if (!i_rst_n)
         full_q <= 1'b0;
      else if (i_flush)
         full_q <= 1'b0;
      else if (i_write)
         full_q <= 1'b1;                     // Also covers read and write together
      else if (i_read)
         full_q <= 1'b0;
   end

   // Payload holds until the next write
   always_ff @(posedge clk_in)
   begin
      if (i_write)
         data_q <= i_data;
   end

   assign o_full = full_q;
   assign o_data = data_q;

endmodule

/* exe_result_sel.sv */
// Builds the memory-stage record and PC reload; outputs are zero when decode is not valid
`timescale 1ns/1ps

module exe_result_sel
   import exe_pkg::*;
(
   input  logic             i_dec_valid,
   input  dec_to_exe_t      i_dec,
   input  logic [XLEN-1:0]  i_rs2_val,       // Store data
   input  logic [XLEN-1:0]  i_rs1_val,       // Load/store base
   input  logic [XLEN-1:0]  i_alu_result,
   input  br_res_t          i_br_res,
   output exe_to_mem_t      o_exe_dout,
   output logic             o_rld_pc,        // Fetch must reload
   output logic [PC_SZ-1:0] o_rld_pc_addr
);

   logic [XLEN-1:0] ls_addr;
   logic            ls_mis;
   logic            in_ic;
   logic            mispre;

   // -------------------- Load/store address
   assign ls_addr = i_rs1_val + i_dec.imm;
   assign in_ic   = (ls_addr >= L1_IC_LO) && (ls_addr <= L1_IC_HI);
   assign mispre  = (i_br_res.br_pc != i_dec.predicted_addr);

   always_comb
   begin
      unique case (i_dec.ls_size)
         HALF:    ls_mis = ls_addr[0];
         WORD:    ls_mis = (ls_addr[1:0] != 2'b00);
         default: ls_mis = 1'b0;             // Bytes are always aligned
      endcase
   end

   // -------------------- Record
   always_comb
   begin
      o_exe_dout    = '0;
      o_rld_pc      = 1'b0;
      o_rld_pc_addr = '0;
      if (i_dec_valid)
      begin
         o_exe_dout.pc             = i_dec.pc;
         o_exe_dout.i_type         = i_dec.i_type;
         o_exe_dout.predicted_addr = i_dec.predicted_addr;
         o_exe_dout.rd_addr        = i_dec.rd_addr;
         unique case (i_dec.i_type)
            ALU:
            begin
               o_exe_dout.rd_wr   = i_dec.rd_wr;
               o_exe_dout.rd_data = i_alu_result;
            end
            BR:
            begin
               o_exe_dout.br_pc = i_br_res.br_pc;
               if (mispre)
               begin
                  o_exe_dout.mispre = 1'b1;  // Younger instructions get flushed
                  o_rld_pc          = 1'b1;
                  o_rld_pc_addr     = i_br_res.br_pc;
               end
               else if (i_dec.br_op inside {JAL, JALR})
               begin
                  o_exe_dout.rd_wr   = i_dec.rd_wr;
                  o_exe_dout.rd_data = i_br_res.link_pc;
               end
            end
            LD, ST:
            begin
               o_exe_dout.is_ld    = (i_dec.i_type == LD);
               o_exe_dout.is_st    = (i_dec.i_type == ST);
               o_exe_dout.rd_wr    = (i_dec.i_type == LD) && i_dec.rd_wr;   // Data comes in MEM
               o_exe_dout.ls_addr  = ls_addr;
               o_exe_dout.ls_size  = i_dec.ls_size;
               o_exe_dout.zero_ext = i_dec.ls_unsigned;
               o_exe_dout.mis      = ls_mis;
               if (i_dec.i_type == ST)
               begin
                  o_exe_dout.st_data  = i_rs2_val;
                  o_exe_dout.inv_flag = in_ic;                  // Self-modifying code
               end
            end
            default:
            begin
               o_exe_dout.rd_addr = '0;      // ILL passes as a bubble
            end
         endcase
         if (o_exe_dout.rd_addr == '0)
            o_exe_dout.rd_wr = 1'b0;         // x0 is hardwired
      end
   end

endmodule

/* exe_branch.sv */
// Branch and jump resolution; C extension assumed, so no target misalignment is flagged
`timescale 1ns/1ps

module exe_branch
   import exe_pkg::*;
(
   input  dec_to_exe_t     i_dec,
   input  logic [XLEN-1:0] i_rs1_val,
   input  logic [XLEN-1:0] i_rs2_val,
   output br_res_t         o_br_res
);

   logic             eq;
   logic             lt_s;                   // Signed less than
   logic             lt_u;                   // Unsigned less than
   logic             taken;
   logic [PC_SZ-1:0] seq_pc;                 // Next sequential PC
   logic [PC_SZ-1:0] pc_rel;                 // PC relative target
   logic [PC_SZ-1:0] reg_rel;                // JALR target

   // -------------------- Compare
   assign eq   = (i_rs1_val == i_rs2_val);
   assign lt_s = ($signed(i_rs1_val) < $signed(i_rs2_val));
   assign lt_u = (i_rs1_val < i_rs2_val);

   always_comb
   begin
      unique case (i_dec.br_op)
         BEQ:  taken = eq;
         BNE:  taken = !eq;
         BLT:  taken = lt_s;
         BGE:  taken = !lt_s;
         BLTU: taken = lt_u;
         BGEU: taken = !lt_u;
         JAL,
         JALR: taken = 1'b1;                 // Jumps always go
         default:
         begin
            taken = 1'b0;
         end
      endcase
   end

   // -------------------- Targets
   assign seq_pc  = i_dec.pc + 32'd4;
   assign pc_rel  = i_dec.pc + i_dec.imm;
   assign reg_rel = (i_rs1_val + i_dec.imm) & ~32'd1;   // Bit 0 cleared per spec

   always_comb
   begin
      o_br_res.taken   = taken;
      o_br_res.link_pc = seq_pc;             // Written to rd by JAL / JALR
      if (!taken)
         o_br_res.br_pc = seq_pc;            // Fall through
      else if (i_dec.br_op == JALR)
         o_br_res.br_pc = reg_rel;
      else
         o_br_res.br_pc = pc_rel;            // Bxx and JAL
   end

endmodule

/* exe_alu.sv */
// Single-cycle integer ALU; shift amount is the low 5 bits of y, no overflow detection
`timescale 1ns/1ps

module exe_alu
   import exe_pkg::*;
(
   input  dec_to_exe_t     i_dec,
   input  logic [XLEN-1:0] i_rs1_val,        // Forwarded rs1
   input  logic [XLEN-1:0] i_rs2_val,        // Forwarded rs2
   output logic [XLEN-1:0] o_result
);

   logic [XLEN-1:0] x_op;
   logic [XLEN-1:0] y_op;
   logic [4:0]      shamt;

   // -------------------- Operand select
   assign x_op  = i_dec.sel_x_pc  ? i_dec.pc  : i_rs1_val;   // AUIPC uses PC
   assign y_op  = i_dec.sel_y_imm ? i_dec.imm : i_rs2_val;   // I-type uses imm
   assign shamt = y_op[4:0];

   // -------------------- Operation
   always_comb
   begin
      unique case (i_dec.alu_op)
         ADD:  o_result = x_op + y_op;
         SUB:  o_result = x_op - y_op;
         SLL:  o_result = x_op << shamt;
         SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(x_op) < $signed(y_op)};
         SLTU: o_result = {{(XLEN-1){1'b0}}, x_op < y_op};
         XOR:  o_result = x_op ^ y_op;
         SRL:  o_result = x_op >> shamt;
         SRA:  o_result = $unsigned($signed(x_op) >>> shamt);  // Sign fill
         OR:   o_result = x_op | y_op;
         AND:  o_result = x_op & y_op;
         LUI:  o_result = y_op;              // Upper immediate already shifted in decode
         default:
         begin
            o_result = '0;                   // Unused encodings
         end
      endcase
   end

endmodule

/* exe_forward.sv */
// Operand forwarding; memory result wins over writeback, x0 is never forwarded
`timescale 1ns/1ps

module exe_forward
   import exe_pkg::*;
(
   input  dec_to_exe_t     i_dec,            // Decoded instruction with register data
   input  fwd_t            i_fwd_mem,        // Result from memory stage
   input  fwd_t            i_fwd_wb,         // Result from writeback stage
   output logic [XLEN-1:0] o_rs1_val,
   output logic [XLEN-1:0] o_rs2_val
);

   // Does a forwarded result target this source register
   function automatic logic fwd_hit(
      input fwd_t               fwd,
      input logic               src_rd,
      input logic [GPR_ASZ-1:0] src_addr
   );
      return src_rd && fwd.valid && fwd.rd_wr &&
             (fwd.rd_addr == src_addr) && (src_addr != '0);
   endfunction

   // Priority pick, newest result first
   function automatic logic [XLEN-1:0] fwd_pick(
      input logic               src_rd,
      input logic [GPR_ASZ-1:0] src_addr,
      input logic [XLEN-1:0]    src_data
   );
      if (fwd_hit(i_fwd_mem, src_rd, src_addr))
         return i_fwd_mem.rd_data;           // Memory stage is newer
      else if (fwd_hit(i_fwd_wb, src_rd, src_addr))
         return i_fwd_wb.rd_data;
      else
         return src_data;                    // Value read in decode
   endfunction

   always_comb
   begin
      o_rs1_val = fwd_pick(i_dec.rs1_rd, i_dec.rs1_addr, i_dec.rs1_data);
      o_rs2_val = fwd_pick(i_dec.rs2_rd, i_dec.rs2_addr, i_dec.rs2_data);
   end

endmodule

/* exe_pkg.sv */
// Shared types for the RV32I execute stage; RV32I only, no CSR, M or F state, IC range fixed here
package exe_pkg;

   // -------------------- Widths
   localparam int XLEN    = 32;                  // Register and data width
   localparam int PC_SZ   = 32;                  // Program counter width
   localparam int GPR_ASZ = 5;                   // x0..x31

   // L1 I-cache byte range, inclusive on both ends
   localparam logic [PC_SZ-1:0] L1_IC_LO = 32'h0000_1000;
   localparam logic [PC_SZ-1:0] L1_IC_HI = 32'h0000_1FFF;

   // -------------------- Opcodes
   typedef enum logic [2:0] {ALU, BR, LD, ST, ILL} instr_type_e;

   // LUI passes the y operand straight through
   typedef enum logic [3:0] {
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI
   } alu_op_e;

   typedef enum logic [2:0] {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR} br_op_e;

   typedef enum logic [1:0] {BYTE, HALF, WORD} ls_size_e;

   // -------------------- Records
   // Decode to execute, register file already read in decode
   typedef struct packed {
      logic [PC_SZ-1:0]   pc;
      logic [XLEN-1:0]    imm;
      logic [PC_SZ-1:0]   predicted_addr;    // Fetch prediction for next PC
      logic [XLEN-1:0]    rs1_data;
      logic [XLEN-1:0]    rs2_data;
      logic [GPR_ASZ-1:0] rd_addr;
      logic [GPR_ASZ-1:0] rs1_addr;
      logic [GPR_ASZ-1:0] rs2_addr;
      logic               rd_wr;
      logic               rs1_rd;            // Instruction reads rs1
      logic               rs2_rd;            // Instruction reads rs2
      instr_type_e        i_type;
      alu_op_e            alu_op;
      br_op_e             br_op;
      ls_size_e           ls_size;
      logic               ls_unsigned;       // LBU / LHU
      logic               sel_x_pc;          // ALU x operand is PC
      logic               sel_y_imm;         // ALU y operand is imm
   } dec_to_exe_t;

   // Result forwarded back from a later stage
   typedef struct packed {
      logic               valid;
      logic               rd_wr;
      logic [GPR_ASZ-1:0] rd_addr;
      logic [XLEN-1:0]    rd_data;
   } fwd_t;

   // Execute to memory
   typedef struct packed {
      logic [PC_SZ-1:0]   pc;
      instr_type_e        i_type;
      logic [PC_SZ-1:0]   predicted_addr;
      logic [PC_SZ-1:0]   br_pc;             // Resolved next PC, branches only
      logic               mispre;
      logic               rd_wr;
      logic [GPR_ASZ-1:0] rd_addr;
      logic [XLEN-1:0]    rd_data;
      logic               is_ld;
      logic               is_st;
      logic [XLEN-1:0]    ls_addr;
      logic [XLEN-1:0]    st_data;
      ls_size_e           ls_size;
      logic               zero_ext;
      logic               mis;               // Load/store address misaligned
      logic               inv_flag;          // Store hits the I-cache range
   } exe_to_mem_t;

   // Branch unit result
   typedef struct packed {
      logic               taken;
      logic [PC_SZ-1:0]   br_pc;             // Target if taken, else PC + 4
      logic [PC_SZ-1:0]   link_pc;           // PC + 4
   } br_res_t;

endpackage
